//--- data_access_unit.f
source/dcache_pkg.sv
source/dcache_ifs.sv
source/line_store.sv
source/line_refill.sv
source/store_writer.sv
source/mem_arbiter.sv
source/access_control.sv
source/data_access_unit.sv
test/tb_data_access_unit.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_data_access_unit \
	-f data_access_unit.f -o tb_sim > build.log 2>&1 \
	|| { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || echo "Simulation ended with an error status"
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log || { echo "No pass result in log"; exit 1; }
echo "Simulation passed"
exit 0

//--- source/access_control.sv
// Load/store access controller

`timescale 1ns/1ps

module access_control (
	input wire iCLOCK,
	input wire inRESET,
	input wire req_valid,
	output logic req_ready,
	input wire req_write,
	input dcache_pkg::addr_t req_addr,
	input dcache_pkg::word_t req_wdata,
	output logic rsp_valid,
	input wire rsp_ready,
	output dcache_pkg::word_t rsp_rdata,
	output logic io_req_valid,
	input wire io_req_ready,
	output logic io_write,
	output dcache_pkg::addr_t io_addr,
	output dcache_pkg::word_t io_wdata,
	input wire io_rsp_valid,
	input dcache_pkg::word_t io_rdata,
	input wire iosr_valid,
	input dcache_pkg::addr_t iosr,
	output dcache_pkg::addr_t lookup_addr,
	input wire lookup_hit,
	input dcache_pkg::word_t lookup_rdata,
	output logic update_en,
	output dcache_pkg::word_t update_data,
	refill_if.control refill,
	store_if.source store
);

	dcache_pkg::ctrl_state_t state;
	logic iosr_valid_q;
	dcache_pkg::addr_t iosr_q;
	logic refill_started;
	logic io_req_q;
	logic req_write_q;
	dcache_pkg::addr_t req_addr_q;
	dcache_pkg::word_t req_wdata_q;
	dcache_pkg::addr_t io_addr_q;
	dcache_pkg::word_t rsp_data_q;
	logic accept;
	logic route_io;
	dcache_pkg::word_t miss_word;

	// I/O start address register
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			iosr_valid_q <= 1'b0;
			iosr_q <= '0;
		end else if (iosr_valid) begin
			iosr_valid_q <= 1'b1;
			iosr_q <= iosr;
		end
	end

	assign req_ready = (state == dcache_pkg::IDLE);
	assign accept = req_valid && req_ready;
	// Nothing is I/O until a start address is set
	assign route_io = iosr_valid_q && (req_addr >= iosr_q);

	// Lookup follows the live request in IDLE, the latched one after
	assign lookup_addr = (state == dcache_pkg::IDLE) ? req_addr : req_addr_q;
	assign update_en = store.valid && store.ready && lookup_hit;
	assign update_data = req_wdata_q;

	// A read waits for the store engine to drain before refilling
	assign refill.start = (state == dcache_pkg::REFILL) && !refill_started
		&& store.ready && !refill.busy;
	assign refill.line_addr = {req_addr_q[31:4], 4'h0};
	assign miss_word = refill.line[32*req_addr_q[3:2] +: 32];

	assign store.valid = (state == dcache_pkg::STORE);
	assign store.addr = req_addr_q;
	assign store.wdata = req_wdata_q;

	assign io_req_valid = io_req_q;
	assign io_write = req_write_q;
	assign io_addr = io_addr_q;
	assign io_wdata = req_wdata_q;

	assign rsp_valid = (state == dcache_pkg::HIT_RSP) || (state == dcache_pkg::MISS_RSP)
		|| (state == dcache_pkg::RSP_HOLD);
	assign rsp_rdata = rsp_data_q;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= dcache_pkg::IDLE;
			refill_started <= 1'b0;
			io_req_q <= 1'b0;
		end else begin
			case (state)
				dcache_pkg::IDLE: begin
					if (accept) begin
						if (route_io) begin
							state <= dcache_pkg::IO_WAIT;
							io_req_q <= 1'b1;
						end else if (req_write) begin
							state <= dcache_pkg::STORE;
						end else if (lookup_hit) begin
							state <= dcache_pkg::HIT_RSP;
						end else begin
							state <= dcache_pkg::REFILL;
						end
					end
				end
				dcache_pkg::REFILL: begin
					if (refill.start) begin
						refill_started <= 1'b1;
					end
					if (refill.done) begin
						refill_started <= 1'b0;
						state <= dcache_pkg::MISS_RSP;
					end
				end
				dcache_pkg::STORE: begin
					if (store.ready) begin
						state <= dcache_pkg::RSP_HOLD;
					end
				end
				dcache_pkg::IO_WAIT: begin
					if (io_req_q && io_req_ready) begin
						io_req_q <= 1'b0;
					end
					if (io_rsp_valid) begin
						state <= dcache_pkg::RSP_HOLD;
					end
				end
				// Response held until taken
				dcache_pkg::HIT_RSP, dcache_pkg::MISS_RSP, dcache_pkg::RSP_HOLD: begin
					if (rsp_ready) begin
						state <= dcache_pkg::IDLE;
					end
				end
				default: state <= dcache_pkg::IDLE;
			endcase
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (accept) begin
			req_write_q <= req_write;
			req_addr_q <= req_addr;
			req_wdata_q <= req_wdata;
			io_addr_q <= req_addr - iosr_q;
			rsp_data_q <= lookup_rdata;
		end
		if ((state == dcache_pkg::REFILL) && refill.done) begin
			rsp_data_q <= miss_word;
		end
		if ((state == dcache_pkg::IO_WAIT) && io_rsp_valid) begin
			rsp_data_q <= io_rdata;
		end
	end

	// A finished line must find the controller still waiting for it
	a_done_in_refill: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		refill.done |-> (state == dcache_pkg::REFILL));

endmodule

//--- source/data_access_unit.sv
// Data access unit top level

`timescale 1ns/1ps

module data_access_unit (
	input wire iCLOCK,
	input wire inRESET,
	// Load/store request and response
	input wire req_valid,
	output logic req_ready,
	input wire req_write,
	input dcache_pkg::addr_t req_addr,
	input dcache_pkg::word_t req_wdata,
	output logic rsp_valid,
	input wire rsp_ready,
	output dcache_pkg::word_t rsp_rdata,
	// I/O port
	output logic io_req_valid,
	input wire io_req_ready,
	output logic io_write,
	output dcache_pkg::addr_t io_addr,
	output dcache_pkg::word_t io_wdata,
	input wire io_rsp_valid,
	input dcache_pkg::word_t io_rdata,
	input wire iosr_valid,
	input dcache_pkg::addr_t iosr,
	input wire cache_flush,
	// Main memory bus
	output logic mem_req_valid,
	input wire mem_req_ready,
	output logic mem_write,
	output dcache_pkg::addr_t mem_addr,
	output dcache_pkg::word_t mem_wdata,
	input wire mem_rsp_valid,
	input dcache_pkg::word_t mem_rdata
);

	dcache_pkg::addr_t lookup_addr;
	logic lookup_hit;
	dcache_pkg::word_t lookup_rdata;
	logic update_en;
	dcache_pkg::word_t update_data;

	mem_bus_if refill_mem ();
	mem_bus_if store_mem ();
	refill_if refill_bus ();
	store_if store_bus ();

	access_control ctrl_i (
		.iCLOCK(iCLOCK), .inRESET(inRESET),
		.req_valid(req_valid), .req_ready(req_ready), .req_write(req_write),
		.req_addr(req_addr), .req_wdata(req_wdata),
		.rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp_rdata(rsp_rdata),
		.io_req_valid(io_req_valid), .io_req_ready(io_req_ready), .io_write(io_write),
		.io_addr(io_addr), .io_wdata(io_wdata),
		.io_rsp_valid(io_rsp_valid), .io_rdata(io_rdata),
		.iosr_valid(iosr_valid), .iosr(iosr),
		.lookup_addr(lookup_addr), .lookup_hit(lookup_hit), .lookup_rdata(lookup_rdata),
		.update_en(update_en), .update_data(update_data),
		.refill(refill_bus), .store(store_bus)
	);

	line_store lines_i (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .flush(cache_flush),
		.lookup_addr(lookup_addr), .lookup_hit(lookup_hit), .lookup_rdata(lookup_rdata),
		.update_en(update_en), .update_data(update_data),
		.refill(refill_bus)
	);

	line_refill refill_i (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .refill(refill_bus), .mem(refill_mem)
	);

	store_writer store_i (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .store(store_bus), .mem(store_mem)
	);

	mem_arbiter arb_i (
		.iCLOCK(iCLOCK), .inRESET(inRESET),
		.refill_mem(refill_mem), .store_mem(store_mem),
		.mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready),
		.mem_write(mem_write), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.mem_rsp_valid(mem_rsp_valid), .mem_rdata(mem_rdata)
	);

endmodule

//--- source/dcache_ifs.sv
// Data cache internal interfaces

`timescale 1ns/1ps

// Memory request port with response strobe
interface mem_bus_if;
	logic req_valid;
	logic req_ready;
	logic write;
	dcache_pkg::addr_t addr;
	dcache_pkg::word_t wdata;
	logic rsp_valid;
	dcache_pkg::word_t rdata;

	modport requester (
		output req_valid, write, addr, wdata,
		input req_ready, rsp_valid, rdata
	);

	modport arbiter (
		input req_valid, write, addr, wdata,
		output req_ready, rsp_valid, rdata
	);
endinterface

// Line refill control
interface refill_if;
	logic start;
	dcache_pkg::addr_t line_addr;
	logic busy;
	logic done;
	dcache_pkg::line_t line;

	modport control (output start, line_addr, input busy, done, line);
	modport engine (input start, line_addr, output busy, done, line);
	modport monitor (input done, line_addr, line);
endinterface

// Store hand-off to the write-through engine
interface store_if;
	logic valid;
	logic ready;
	dcache_pkg::addr_t addr;
	dcache_pkg::word_t wdata;

	modport source (output valid, addr, wdata, input ready);
	modport sink (input valid, addr, wdata, output ready);
endinterface

//--- source/dcache_pkg.sv
// Data cache shared definitions

package dcache_pkg;

	// Cache geometry
	localparam int LINE_COUNT = 16;
	localparam int LINE_WORDS = 4;

	// Byte address and data word
	typedef logic [31:0] addr_t;
	typedef logic [31:0] word_t;

	// One full cache line, word 0 in the low bits
	typedef logic [127:0] line_t;

	// Address fields: tag 31..8, index 7..4, word 3..2
	typedef logic [3:0] index_t;
	typedef logic [23:0] tag_t;
	typedef logic [1:0] word_sel_t;

	// Access controller states
	typedef enum logic [2:0] {
		IDLE,
		HIT_RSP,
		REFILL,
		MISS_RSP,
		STORE,
		IO_WAIT,
		RSP_HOLD
	} ctrl_state_t;

endpackage

//--- source/line_refill.sv
// Cache line refill engine

`timescale 1ns/1ps

module line_refill (
	input wire iCLOCK,
	input wire inRESET,
	refill_if.engine refill,
	mem_bus_if.requester mem
);

	logic busy_q;
	logic done_q;
	logic req_q;
	dcache_pkg::word_sel_t word_cnt;
	dcache_pkg::line_t line_buf;

	assign refill.busy = busy_q;
	assign refill.done = done_q;
	assign refill.line = line_buf;

	// Reads only, one word at a time
	assign mem.req_valid = req_q;
	assign mem.write = 1'b0;
	assign mem.addr = {refill.line_addr[31:4], word_cnt, 2'b00};
	assign mem.wdata = '0;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			busy_q <= 1'b0;
			done_q <= 1'b0;
			req_q <= 1'b0;
			word_cnt <= '0;
		end else begin
			done_q <= 1'b0;
			if (refill.start) begin
				busy_q <= 1'b1;
				req_q <= 1'b1;
				word_cnt <= '0;
			end else begin
				if (req_q && mem.req_ready) begin
					req_q <= 1'b0;
				end
				if (mem.rsp_valid) begin
					if (word_cnt == dcache_pkg::word_sel_t'(dcache_pkg::LINE_WORDS - 1)) begin
						busy_q <= 1'b0;
						done_q <= 1'b1;
					end else begin
						// Next word goes out after this response
						word_cnt <= word_cnt + 2'd1;
						req_q <= 1'b1;
					end
				end
			end
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (mem.rsp_valid) begin
			line_buf[32*word_cnt +: 32] <= mem.rdata;
		end
	end

	a_no_start_busy: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		refill.start |-> !busy_q);

endmodule

//--- source/line_store.sv
// Direct-mapped tag and data arrays

`timescale 1ns/1ps

module line_store (
	input wire iCLOCK,
	input wire inRESET,
	input wire flush,
	input dcache_pkg::addr_t lookup_addr,
	output logic lookup_hit,
	output dcache_pkg::word_t lookup_rdata,
	input wire update_en,
	input dcache_pkg::word_t update_data,
	refill_if.monitor refill
);

	dcache_pkg::tag_t tag_arr [dcache_pkg::LINE_COUNT];
	dcache_pkg::line_t data_arr [dcache_pkg::LINE_COUNT];
	logic [dcache_pkg::LINE_COUNT-1:0] valid_bits;

	dcache_pkg::index_t lk_index;
	dcache_pkg::tag_t lk_tag;
	dcache_pkg::word_sel_t lk_word;
	dcache_pkg::index_t rf_index;

	assign lk_index = lookup_addr[7:4];
	assign lk_tag = lookup_addr[31:8];
	assign lk_word = lookup_addr[3:2];
	assign rf_index = refill.line_addr[7:4];

	// Combinational lookup
	assign lookup_hit = valid_bits[lk_index] && (tag_arr[lk_index] == lk_tag);
	assign lookup_rdata = data_arr[lk_index][32*lk_word +: 32];

	// Flush wins over a refill finishing in the same cycle
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			valid_bits <= '0;
		end else if (flush) begin
			valid_bits <= '0;
		end else if (refill.done) begin
			valid_bits[rf_index] <= 1'b1;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (refill.done) begin
			tag_arr[rf_index] <= refill.line_addr[31:8];
			data_arr[rf_index] <= refill.line;
		end else if (update_en) begin
			// Write-through hit keeps the cached copy current
			data_arr[lk_index][32*lk_word +: 32] <= update_data;
		end
	end

	a_update_on_hit: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		update_en |-> lookup_hit);

endmodule

//--- source/mem_arbiter.sv
// Round-robin memory bus arbiter

`timescale 1ns/1ps

module mem_arbiter (
	input wire iCLOCK,
	input wire inRESET,
	mem_bus_if.arbiter refill_mem,
	mem_bus_if.arbiter store_mem,
	output logic mem_req_valid,
	input wire mem_req_ready,
	output logic mem_write,
	output dcache_pkg::addr_t mem_addr,
	output dcache_pkg::word_t mem_wdata,
	input wire mem_rsp_valid,
	input dcache_pkg::word_t mem_rdata
);

	logic lock_q;
	// Last winner, also the owner while locked
	logic last_store;
	logic pick_store;

	always_comb begin
		if (refill_mem.req_valid && store_mem.req_valid) begin
			pick_store = !last_store;
		end else begin
			pick_store = store_mem.req_valid;
		end
	end

	assign mem_req_valid = !lock_q && (refill_mem.req_valid || store_mem.req_valid);
	assign mem_write = pick_store ? store_mem.write : refill_mem.write;
	assign mem_addr = pick_store ? store_mem.addr : refill_mem.addr;
	assign mem_wdata = pick_store ? store_mem.wdata : refill_mem.wdata;

	assign refill_mem.req_ready = !lock_q && !pick_store && mem_req_ready;
	assign store_mem.req_ready = !lock_q && pick_store && mem_req_ready;

	// Response goes only to the owner of the locked grant
	assign refill_mem.rsp_valid = mem_rsp_valid && lock_q && !last_store;
	assign store_mem.rsp_valid = mem_rsp_valid && lock_q && last_store;
	assign refill_mem.rdata = mem_rdata;
	assign store_mem.rdata = mem_rdata;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			lock_q <= 1'b0;
			last_store <= 1'b0;
		end else if (mem_req_valid && mem_req_ready) begin
			lock_q <= 1'b1;
			last_store <= pick_store;
		end else if (mem_rsp_valid) begin
			lock_q <= 1'b0;
		end
	end

	a_rsp_needs_grant: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		mem_rsp_valid |-> lock_q);

endmodule

//--- source/store_writer.sv
// Posted write-through store engine

`timescale 1ns/1ps

module store_writer (
	input wire iCLOCK,
	input wire inRESET,
	store_if.sink store,
	mem_bus_if.requester mem
);

	logic full_q;
	logic req_q;
	dcache_pkg::addr_t addr_q;
	dcache_pkg::word_t wdata_q;

	// Only an empty buffer takes a new store
	assign store.ready = !full_q;

	assign mem.req_valid = req_q;
	assign mem.write = 1'b1;
	assign mem.addr = addr_q;
	assign mem.wdata = wdata_q;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			full_q <= 1'b0;
			req_q <= 1'b0;
		end else begin
			if (store.valid && !full_q) begin
				full_q <= 1'b1;
				req_q <= 1'b1;
			end else begin
				if (req_q && mem.req_ready) begin
					req_q <= 1'b0;
				end
				// Busy until memory confirms the write
				if (mem.rsp_valid) begin
					full_q <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (store.valid && !full_q) begin
			addr_q <= store.addr;
			wdata_q <= store.wdata;
		end
	end

endmodule

//--- test/tb_data_access_unit.sv
// Data access unit testbench

`timescale 1ns/1ps

module tb_data_access_unit;

	localparam int NUM_STEPS = 24;
	localparam int K_READ = 0;
	localparam int K_WRITE = 1;
	localparam int K_FLUSH = 2;
	localparam int K_SETIO = 3;

	// One table row; reads is the expected memory read count, -1 to skip
	typedef struct {
		int kind;
		logic [31:0] addr;
		logic [31:0] wdata;
		int reads;
		bit to_io;
	} step_t;

	logic iCLOCK = 1'b0;
	logic inRESET;
	logic req_valid;
	logic req_ready;
	logic req_write;
	logic [31:0] req_addr;
	logic [31:0] req_wdata;
	logic rsp_valid;
	logic rsp_ready;
	logic [31:0] rsp_rdata;
	logic io_req_valid;
	logic io_req_ready;
	logic io_write;
	logic [31:0] io_addr;
	logic [31:0] io_wdata;
	logic io_rsp_valid;
	logic [31:0] io_rdata;
	logic iosr_valid;
	logic [31:0] iosr;
	logic cache_flush;
	logic mem_req_valid;
	logic mem_req_ready;
	logic mem_write;
	logic [31:0] mem_addr;
	logic [31:0] mem_wdata;
	logic mem_rsp_valid;
	logic [31:0] mem_rdata;

	logic [31:0] mem_array [256];
	logic [31:0] ref_mem [256];
	logic [31:0] io_regs [64];
	logic [31:0] ref_io [64];
	int mem_reads;
	int mem_reqs;
	int io_reqs;
	bit mem_busy;
	logic [31:0] last_io_addr;
	logic [31:0] io_start;
	step_t steps [NUM_STEPS];

	data_access_unit dut_i (.*);

	always #5 iCLOCK = ~iCLOCK;

	function automatic logic [31:0] fill_word(input int i, input logic [31:0] key);
		return (32'(i) << 2) ^ key;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("Error at %0t: %s is %h, expected %h", $time, name, got, expected);
			$display("TEST RESULT: FAIL");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic load_table();
		steps[0] = '{K_READ, 32'h0000_0040, 32'h0, 4, 1'b0};
		steps[1] = '{K_READ, 32'h0000_0048, 32'h0, 0, 1'b0};
		steps[2] = '{K_WRITE, 32'h0000_0044, 32'hDEAD_0001, 0, 1'b0};
		steps[3] = '{K_READ, 32'h0000_0044, 32'h0, 0, 1'b0};
		steps[4] = '{K_WRITE, 32'h0000_0100, 32'h1234_5678, 0, 1'b0};
		steps[5] = '{K_READ, 32'h0000_0100, 32'h0, 4, 1'b0};
		steps[6] = '{K_READ, 32'h0000_010C, 32'h0, 0, 1'b0};
		steps[7] = '{K_FLUSH, 32'h0, 32'h0, -1, 1'b0};
		steps[8] = '{K_READ, 32'h0000_0048, 32'h0, 4, 1'b0};
		steps[9] = '{K_READ, 32'h0000_0104, 32'h0, 4, 1'b0};
		// High addresses before the I/O start is set
		steps[10] = '{K_READ, 32'h9000_0080, 32'h0, 4, 1'b0};
		steps[11] = '{K_WRITE, 32'h9000_0084, 32'hCAFE_0002, 0, 1'b0};
		steps[12] = '{K_READ, 32'h9000_0084, 32'h0, 0, 1'b0};
		steps[13] = '{K_SETIO, 32'h8000_0000, 32'h0, -1, 1'b0};
		steps[14] = '{K_READ, 32'h8000_0010, 32'h0, 0, 1'b1};
		steps[15] = '{K_WRITE, 32'h8000_0020, 32'h0BAD_F00D, 0, 1'b1};
		steps[16] = '{K_READ, 32'h8000_0020, 32'h0, 0, 1'b1};
		steps[17] = '{K_READ, 32'h0000_0040, 32'h0, 0, 1'b0};
		// Just below and at the window start
		steps[18] = '{K_READ, 32'h7FFF_FFF0, 32'h0, 4, 1'b0};
		steps[19] = '{K_READ, 32'h8000_0000, 32'h0, 0, 1'b1};
		steps[20] = '{K_WRITE, 32'h0000_0200, 32'h5555_AAAA, 0, 1'b0};
		steps[21] = '{K_READ, 32'h0000_0040, 32'h0, 0, 1'b0};
		steps[22] = '{K_READ, 32'h0000_0200, 32'h0, 4, 1'b0};
		steps[23] = '{K_READ, 32'h0000_0048, 32'h0, 0, 1'b0};
	endtask

	task automatic run_access(input step_t s);
		int reads_before;
		int reqs_before;
		int io_before;
		int waited;
		int hold;
		bit quick;
		logic [31:0] offset;
		logic [31:0] expect_data;
		logic [31:0] held;
		reads_before = mem_reads;
		reqs_before = mem_reqs;
		io_before = io_reqs;
		offset = s.addr - io_start;
		if (s.kind == K_WRITE) begin
			if (s.to_io)
				ref_io[offset[7:2]] = s.wdata;
			else
				ref_mem[s.addr[9:2]] = s.wdata;
		end
		expect_data = s.to_io ? ref_io[offset[7:2]] : ref_mem[s.addr[9:2]];
		quick = ($urandom_range(1, 0) == 1);
		@(posedge iCLOCK);
		#1;
		req_valid = 1'b1;
		req_write = (s.kind == K_WRITE);
		req_addr = s.addr;
		req_wdata = s.wdata;
		rsp_ready = quick;
		@(negedge iCLOCK);
		while (!req_ready) @(negedge iCLOCK);
		@(posedge iCLOCK);
		#1 req_valid = 1'b0;
		waited = 1;
		@(negedge iCLOCK);
		while (!rsp_valid) begin
			@(negedge iCLOCK);
			waited++;
		end
		held = rsp_rdata;
		if (quick) begin
			@(posedge iCLOCK);
			#1 rsp_ready = 1'b0;
		end else begin
			// Back-pressure: response must hold and no request may enter
			hold = $urandom_range(3, 1);
			repeat (hold) begin
				@(posedge iCLOCK);
				@(negedge iCLOCK);
				check_value("rsp_valid", rsp_valid, 32'd1);
				check_value("rsp_rdata", rsp_rdata, held);
				check_value("req_ready", req_ready, 32'd0);
			end
			@(posedge iCLOCK);
			#1 rsp_ready = 1'b1;
			@(posedge iCLOCK);
			#1 rsp_ready = 1'b0;
		end
		if (s.kind == K_READ)
			check_value("rsp_rdata", held, expect_data);
		if (s.reads >= 0)
			check_value("memory read count", mem_reads - reads_before, s.reads);
		check_value("I/O request count", io_reqs - io_before, s.to_io ? 1 : 0);
		if (s.to_io) begin
			check_value("io_addr", last_io_addr, offset);
			check_value("memory request count", mem_reqs - reqs_before, 0);
		end
		if (s.kind == K_READ && !s.to_io && s.reads == 0)
			check_value("hit latency", waited, 32'd1);
	endtask

	task automatic apply_step(input step_t s);
		case (s.kind)
			K_FLUSH: begin
				@(posedge iCLOCK);
				#1 cache_flush = 1'b1;
				@(posedge iCLOCK);
				#1 cache_flush = 1'b0;
			end
			K_SETIO: begin
				@(posedge iCLOCK);
				#1;
				iosr_valid = 1'b1;
				iosr = s.addr;
				io_start = s.addr;
				@(posedge iCLOCK);
				#1 iosr_valid = 1'b0;
			end
			default: run_access(s);
		endcase
	endtask

	// Memory: ready after 0 to 3 cycles, response 2 to 5 cycles after accept
	initial begin : memory_model
		int unsigned lag;
		logic wr;
		logic [7:0] idx;
		mem_req_ready = 1'b0;
		mem_rsp_valid = 1'b0;
		mem_rdata = '0;
		mem_busy = 1'b0;
		mem_reads = 0;
		mem_reqs = 0;
		wait (inRESET);
		forever begin
			@(negedge iCLOCK);
			if (mem_req_valid) begin
				mem_busy = 1'b1;
				lag = $urandom_range(3, 0);
				repeat (lag + 1) @(posedge iCLOCK);
				#1 mem_req_ready = 1'b1;
				@(negedge iCLOCK);
				wr = mem_write;
				idx = mem_addr[9:2];
				mem_reqs++;
				if (wr)
					mem_array[idx] = mem_wdata;
				else
					mem_reads++;
				@(posedge iCLOCK);
				#1 mem_req_ready = 1'b0;
				lag = $urandom_range(5, 2);
				repeat (lag - 1) @(posedge iCLOCK);
				#1;
				mem_rsp_valid = 1'b1;
				mem_rdata = mem_array[idx];
				@(posedge iCLOCK);
				#1;
				mem_rsp_valid = 1'b0;
				mem_busy = 1'b0;
			end
		end
	end

	// I/O registers with random accept and answer delays
	initial begin : io_model
		int unsigned lag;
		logic wr;
		logic [5:0] idx;
		io_req_ready = 1'b0;
		io_rsp_valid = 1'b0;
		io_rdata = '0;
		io_reqs = 0;
		last_io_addr = '0;
		wait (inRESET);
		forever begin
			@(negedge iCLOCK);
			if (io_req_valid) begin
				lag = $urandom_range(2, 0);
				repeat (lag + 1) @(posedge iCLOCK);
				#1 io_req_ready = 1'b1;
				@(negedge iCLOCK);
				wr = io_write;
				idx = io_addr[7:2];
				last_io_addr = io_addr;
				io_reqs++;
				if (wr)
					io_regs[idx] = io_wdata;
				@(posedge iCLOCK);
				#1 io_req_ready = 1'b0;
				lag = $urandom_range(4, 1);
				repeat (lag - 1) @(posedge iCLOCK);
				#1;
				io_rsp_valid = 1'b1;
				io_rdata = io_regs[idx];
				@(posedge iCLOCK);
				#1 io_rsp_valid = 1'b0;
			end
		end
	end

	initial begin : watchdog
		repeat (NUM_STEPS * 200 + 8) @(posedge iCLOCK);
		$display("Timeout: the run did not finish within %0d cycles", NUM_STEPS * 200 + 8);
		$display("TEST RESULT: FAIL");
		$fatal(1, "Watchdog expired");
	end

	initial begin : stimulus
		int i;
		void'($urandom(20));
		inRESET = 1'b0;
		req_valid = 1'b0;
		req_write = 1'b0;
		req_addr = '0;
		req_wdata = '0;
		rsp_ready = 1'b0;
		iosr_valid = 1'b0;
		iosr = '0;
		cache_flush = 1'b0;
		io_start = '0;
		for (i = 0; i < 256; i++) begin
			mem_array[i] = fill_word(i, 32'h5A5A_0000);
			ref_mem[i] = fill_word(i, 32'h5A5A_0000);
		end
		for (i = 0; i < 64; i++) begin
			io_regs[i] = fill_word(i, 32'h10C0_0000);
			ref_io[i] = fill_word(i, 32'h10C0_0000);
		end
		load_table();
		repeat (8) @(posedge iCLOCK);
		#1 inRESET = 1'b1;
		for (i = 0; i < NUM_STEPS; i++)
			apply_step(steps[i]);
		// Let posted writes drain before comparing the models
		@(negedge iCLOCK);
		while (mem_req_valid || mem_busy) @(negedge iCLOCK);
		for (i = 0; i < 256; i++)
			check_value($sformatf("mem_array[%0d]", i), mem_array[i], ref_mem[i]);
		for (i = 0; i < 64; i++)
			check_value($sformatf("io_regs[%0d]", i), io_regs[i], ref_io[i]);
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule
